/* bench/l1_refill_props.sv */
`timescale 1ns/10ps
`default_nettype none

module l1_refill_props (
  input wire l1_refill_clk,
  input wire cpurst_b,
  input wire ipb_req,
  input wire idle,
  input wire icache_wr,
  input wire refill_on,
  input wire icache_first,
  input wire icache_last
);

  // Request only fresh out of idle
  a_req_from_idle: assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    $rose(ipb_req) |-> $past(idle))
    else $error("ipb_req rose without a preceding idle cycle");

  a_wr_refill_on: assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    icache_wr |-> refill_on)
    else $error("icache_wr outside a refill");

  a_first_last: assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    !(icache_first && icache_last))
    else $error("icache_first and icache_last high together");

endmodule

bind l1_refill_top l1_refill_props u_props (
  .l1_refill_clk (l1_refill_clk),
  .cpurst_b      (cpurst_b),
  .ipb_req       (ipb_req),
  .idle          (idle),
  .icache_wr     (icache_wr),
  .refill_on     (refill_on),
  .icache_first  (icache_first),
  .icache_last   (icache_last)
);

`default_nettype wire

/* bench/l1_refill_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module l1_refill_tb;

  import l1_refill_pkg::*;

  localparam int seed_init  = 4641;
  localparam int wait_limit = 40;

  integer seed;

  logic  l1_refill_clk;
  logic  cpurst_b;
  logic  miss_req;
  logic  inv_on;
  logic  miss_tsize;
  logic  miss_cacheable;
  logic  miss_bufferable;
  logic  miss_supv_mode;
  logic  miss_machine_mode;
  logic  miss_secure;
  pc_t   miss_vpc;
  pc_t   miss_ppc;
  logic  chgflw;
  logic  grant;
  logic  data_vld;
  logic  trans_err;
  data_t rdata;

  logic                ipb_req;
  logic [bus_pc_w-1:0] ipb_vpc;
  logic [bus_pc_w-1:0] ipb_ppc;
  logic                ipb_tsize;
  logic                ipb_cacheable;
  logic                ipb_bufferable;
  logic                ipb_supv_mode;
  logic                ipb_machine_mode;
  logic                ipb_secure;
  logic                icache_wr;
  logic                icache_first;
  logic                icache_last;
  pc_t                 icache_index;
  ptag_t               icache_ptag;
  data_t               icache_data;
  logic                reissue;
  logic                acc_err;
  logic                miss_pre;
  logic                busy;
  logic                idle;
  logic                refill_on;

  // Reference model state, only written by the compare process
  logic m_busy  = 1'b0;
  logic m_req   = 1'b0;
  logic m_fill  = 1'b0;
  logic m_valid = 1'b0;
  logic m_tsize = 1'b0;
  int   m_beat  = 0;
  int   m_last  = 0;
  pc_t  m_vpc   = '0;
  pc_t  m_ppc   = '0;

  int wr_count      = 0;
  int reissue_count = 0;
  int err_count     = 0;

  l1_refill_top dut0 (.*);

  initial
  begin
    l1_refill_clk = 1'b0;
    forever #10 l1_refill_clk = ~l1_refill_clk;
  end

  // ========================================
  // Reference functions and checks
  // ========================================
  // Eight halfwords in reverse order, bytes inside each kept
  function automatic data_t ref_swap(input data_t d);
    data_t       r;
    logic [15:0] hw;
    for (int i = 0; i < 8; i++)
    begin
      hw = d[127-16*i -: 16];
      r[16*i +: 16] = hw;
    end
    return r;
  endfunction

  // Next 16-byte beat inside the 64-byte line
  function automatic pc_t next_offset(input pc_t pc);
    pc_t r;
    r      = pc;
    r[4:3] = pc[4:3] + 2'd1;
    r[2:0] = 3'b000;
    return r;
  endfunction

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_pc(input string name, input pc_t got, input pc_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_ptag(input string name, input ptag_t got, input ptag_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // ========================================
  // Compare process
  // ========================================
  task automatic compare_outputs();
    logic fv;
    logic bt;
    fv = m_fill && m_valid;
    bt = data_vld || trans_err;
    check_bit("ipb_req", ipb_req, m_req);
    check_bit("busy", busy, m_busy);
    check_bit("idle", idle, !m_busy);
    check_bit("refill_on", refill_on, m_req || fv);
    check_bit("icache_wr", icache_wr, fv && data_vld && m_tsize);
    check_bit("icache_first", icache_first, fv && data_vld && m_tsize && (m_beat == 0));
    check_bit("icache_last", icache_last, fv && data_vld && m_tsize && (m_beat == 3));
    check_bit("reissue", reissue, fv && ((data_vld && (m_beat == m_last)) || trans_err));
    check_bit("acc_err", acc_err, fv && trans_err);
    check_bit("miss_pre", miss_pre, fv && bt && (m_beat == 0));
    check_bit("ipb_tsize", ipb_tsize, m_tsize);
    check_pc("icache_index", icache_index, m_vpc);
    check_ptag("icache_ptag", icache_ptag, m_ppc[pc_w-1:ptag_lsb]);
    if (icache_wr)
      check_data("icache_data", icache_data, ref_swap(rdata));
  endtask

  // Inputs seen here are the ones taken at the next rising edge
  task automatic update_model();
    logic bt;
    bt = data_vld || trans_err;
    if (!m_busy)
    begin
      if (miss_req && !inv_on)
      begin
        m_busy  = 1'b1;
        m_req   = 1'b1;
        m_vpc   = miss_vpc;
        m_ppc   = miss_ppc;
        m_tsize = miss_tsize;
        m_last  = miss_tsize ? 3 : 0;
      end
    end
    else if (m_req)
    begin
      if (grant)
      begin
        m_req   = 1'b0;
        m_fill  = 1'b1;
        m_beat  = 0;
        m_valid = !chgflw;
      end
      else if (chgflw)
      begin
        m_req  = 1'b0;
        m_busy = 1'b0;
      end
    end
    else if (bt)
    begin
      if (m_valid && (m_beat < m_last))
      begin
        m_vpc = next_offset(m_vpc);
        m_ppc = next_offset(m_ppc);
      end
      if (trans_err)
        m_valid = 1'b0;
      if (m_beat == m_last)
      begin
        m_fill = 1'b0;
        m_busy = 1'b0;
      end
      else
        m_beat++;
    end
    else if (chgflw && m_valid && (m_beat == 0))
      m_valid = 1'b0;
  endtask

  initial
  begin
    forever
    begin
      @(negedge l1_refill_clk);
      if (cpurst_b)
      begin
        compare_outputs();
        if (icache_wr)
          wr_count++;
        if (reissue)
          reissue_count++;
        if (acc_err)
          err_count++;
        update_model();
      end
    end
  end

  // ========================================
  // Stimulus
  // ========================================
  task automatic advance_cycle();
    @(posedge l1_refill_clk);
    #2;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!idle)
    begin
      advance_cycle();
      n++;
      if (n >= wait_limit)
      begin
        $display("Timed out waiting for the controller to return to idle");
        abort_run();
      end
    end
  endtask

  task automatic wait_req();
    int n;
    n = 0;
    while (!ipb_req)
    begin
      advance_cycle();
      n++;
      if (n >= wait_limit)
      begin
        $display("Timed out waiting for the bus request");
        abort_run();
      end
    end
  endtask

  // Fields are still driven, so compare against the inputs
  task automatic check_captured();
    check_pc("ipb_vpc", ipb_vpc[bus_pc_w-1:1], miss_vpc);
    check_bit("ipb_vpc[0]", ipb_vpc[0], 1'b0);
    check_pc("ipb_ppc", ipb_ppc[bus_pc_w-1:1], miss_ppc);
    check_bit("ipb_ppc[0]", ipb_ppc[0], 1'b0);
    check_bit("ipb_tsize", ipb_tsize, miss_tsize);
    check_bit("ipb_cacheable", ipb_cacheable, miss_cacheable);
    check_bit("ipb_bufferable", ipb_bufferable, miss_bufferable);
    check_bit("ipb_supv_mode", ipb_supv_mode, miss_supv_mode);
    check_bit("ipb_machine_mode", ipb_machine_mode, miss_machine_mode);
    check_bit("ipb_secure", ipb_secure, miss_secure);
  endtask

  task automatic start_miss(input logic tsz, input logic blocked);
    logic [63:0] r64;
    logic [31:0] rnd;
    wait_idle();
    r64               = {$random(seed), $random(seed)};
    miss_vpc          = r64[pc_w-1:0];
    r64               = {$random(seed), $random(seed)};
    miss_ppc          = r64[pc_w-1:0];
    rnd               = $random(seed);
    miss_tsize        = tsz;
    miss_cacheable    = rnd[0];
    miss_bufferable   = rnd[1];
    miss_supv_mode    = rnd[2];
    miss_machine_mode = rnd[3];
    miss_secure       = rnd[4];
    miss_req          = 1'b1;
    inv_on            = blocked;
    advance_cycle();
    miss_req = 1'b0;
    inv_on   = 1'b0;
    if (!blocked)
      check_captured();
  endtask

  // Mode 1 flushes with the grant, mode 2 one cycle later
  task automatic grant_line(input int chg_mode);
    logic [31:0] rnd;
    int          delay;
    rnd   = $random(seed);
    delay = 1 + rnd % 4;
    repeat (delay - 1) advance_cycle();
    grant  = 1'b1;
    chgflw = (chg_mode == 1);
    advance_cycle();
    grant  = 1'b0;
    chgflw = 1'b0;
    if (chg_mode == 2)
    begin
      chgflw = 1'b1;
      advance_cycle();
      chgflw = 1'b0;
    end
  endtask

  task automatic send_beats(input int n, input int err_at);
    logic [31:0] rnd;
    int          gap;
    for (int i = 0; i < n; i++)
    begin
      rnd = $random(seed);
      gap = rnd % 3;
      repeat (gap) advance_cycle();
      rdata = {$random(seed), $random(seed), $random(seed), $random(seed)};
      if (i == err_at)
        trans_err = 1'b1;
      else
        data_vld = 1'b1;
      advance_cycle();
      data_vld  = 1'b0;
      trans_err = 1'b0;
    end
  endtask

  task automatic run_line(input logic tsz, input int chg_mode, input int err_at,
                          input int exp_wr, input int exp_reissue, input int exp_err);
    int wr0;
    int re0;
    int er0;
    wr0 = wr_count;
    re0 = reissue_count;
    er0 = err_count;
    start_miss(tsz, 1'b0);
    wait_req();
    grant_line(chg_mode);
    send_beats(tsz ? 4 : 1, err_at);
    check_bit("idle after line", idle, 1'b1);
    check_count("icache_wr beats", wr_count - wr0, exp_wr);
    check_count("reissue pulses", reissue_count - re0, exp_reissue);
    check_count("acc_err pulses", err_count - er0, exp_err);
  endtask

  // Stray beats after the withdrawn request must not reach the array
  task automatic run_req_cancel();
    int wr0;
    wr0 = wr_count;
    start_miss(1'b1, 1'b0);
    wait_req();
    chgflw = 1'b1;
    advance_cycle();
    chgflw = 1'b0;
    check_bit("ipb_req after chgflw", ipb_req, 1'b0);
    check_bit("idle after chgflw", idle, 1'b1);
    send_beats(4, -1);
    check_count("icache_wr beats", wr_count - wr0, 0);
  endtask

  task automatic run_blocked_miss();
    start_miss(1'b1, 1'b1);
    check_bit("busy with inv_on", busy, 1'b0);
    check_bit("ipb_req with inv_on", ipb_req, 1'b0);
    advance_cycle();
    check_bit("idle with inv_on", idle, 1'b1);
  endtask

  initial
  begin
    seed              = seed_init;
    cpurst_b          = 1'b0;
    miss_req          = 1'b0;
    inv_on            = 1'b0;
    miss_tsize        = 1'b0;
    miss_cacheable    = 1'b0;
    miss_bufferable   = 1'b0;
    miss_supv_mode    = 1'b0;
    miss_machine_mode = 1'b0;
    miss_secure       = 1'b0;
    miss_vpc          = '0;
    miss_ppc          = '0;
    chgflw            = 1'b0;
    grant             = 1'b0;
    data_vld          = 1'b0;
    trans_err         = 1'b0;
    rdata             = '0;
    repeat (3) @(posedge l1_refill_clk);
    #2;
    cpurst_b = 1'b1;
    advance_cycle();
    repeat (4)
    begin
      run_line(1'b1, 0, -1, 4, 1, 0);
      run_line(1'b0, 0, -1, 0, 1, 0);
      run_req_cancel();
      run_line(1'b1, 2, -1, 0, 0, 0);
      run_line(1'b1, 1, -1, 0, 0, 0);
      // Error on the second beat
      run_line(1'b1, 0, 1, 1, 1, 1);
      run_line(1'b0, 0, 0, 0, 1, 1);
      run_blocked_miss();
    end
    wait_idle();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/l1_refill_addr.sv */
`timescale 1ns/10ps
`default_nettype none

module l1_refill_addr (
  input  wire                                 l1_refill_clk,
  input  wire                                 cpurst_b,
  input  wire                                 start,
  input  wire                                 offset_inc,
  input  l1_refill_pkg::pc_t                  miss_vpc,
  input  l1_refill_pkg::pc_t                  miss_ppc,
  output l1_refill_pkg::pc_t                  icache_index,
  output l1_refill_pkg::ptag_t                icache_ptag,
  output logic [l1_refill_pkg::bus_pc_w-1:0]  ipb_vpc,
  output logic [l1_refill_pkg::bus_pc_w-1:0]  ipb_ppc
);

  import l1_refill_pkg::*;

  pc_t vpc;
  pc_t ppc;

  // ========================================
  // PC registers
  // ========================================
  // Offset wraps inside the 64-byte line, low bits cleared
  always_ff @(posedge l1_refill_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      vpc <= '0;
      ppc <= '0;
    end
    else if (start)
    begin
      vpc <= miss_vpc;
      ppc <= miss_ppc;
    end
    else if (offset_inc)
    begin
      vpc <= {vpc[pc_w-1:5], vpc[4:3] + 2'd1, 3'b000};
      ppc <= {ppc[pc_w-1:5], ppc[4:3] + 2'd1, 3'b000};
    end
  end

  assign icache_index = vpc;
  assign icache_ptag  = ppc[ptag_lsb +: ptag_w];

  // Bus wants byte addresses
  assign ipb_vpc = {vpc, 1'b0};
  assign ipb_ppc = {ppc, 1'b0};

endmodule

`default_nettype wire

/* hw/l1_refill_attr.sv */
`timescale 1ns/10ps
`default_nettype none

module l1_refill_attr (
  input  wire  l1_refill_clk,
  input  wire  cpurst_b,
  input  wire  start,
  input  wire  miss_tsize,
  input  wire  miss_cacheable,
  input  wire  miss_bufferable,
  input  wire  miss_supv_mode,
  input  wire  miss_machine_mode,
  input  wire  miss_secure,
  output logic tsize,
  output logic cacheable,
  output logic bufferable,
  output logic supv_mode,
  output logic machine_mode,
  output logic secure
);

  // Transfer size and protection, held for the whole request
  always_ff @(posedge l1_refill_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      tsize        <= 1'b0;
      cacheable    <= 1'b0;
      bufferable   <= 1'b0;
      supv_mode    <= 1'b0;
      machine_mode <= 1'b0;
      secure       <= 1'b0;
    end
    else if (start)
    begin
      tsize        <= miss_tsize;
      cacheable    <= miss_cacheable;
      bufferable   <= miss_bufferable;
      supv_mode    <= miss_supv_mode;
      machine_mode <= miss_machine_mode;
      secure       <= miss_secure;
    end
  end

endmodule

`default_nettype wire

/* hw/l1_refill_beat.sv */
`timescale 1ns/10ps
`default_nettype none

module l1_refill_beat (
  input  l1_refill_pkg::refill_state_t state,
  input  wire                          tsize,
  input  wire                          data_vld,
  input  wire                          trans_err,
  output logic                         offset_inc,
  output logic                         icache_wr,
  output logic                         icache_first,
  output logic                         icache_last,
  output logic                         reissue,
  output logic                         acc_err,
  output logic                         miss_pre
);

  import l1_refill_pkg::*;

  logic fill;
  logic beat;

  // Valid fill state, discarded beats never write
  assign fill = state[st_fill_bit] && !state[st_inv_bit];
  assign beat = data_vld || trans_err;

  // ========================================
  // Icache write port
  // ========================================
  // Single-beat transfers are not written to the array
  assign icache_wr    = fill && data_vld && tsize;
  assign icache_first = (state == WFD1) && data_vld && tsize;
  assign icache_last  = (state == WFD4) && data_vld;

  // Step bits 4:3 after beats one to three of a line
  assign offset_inc = beat &&
                      (((state == WFD1) && tsize) ||
                       (state == WFD2) ||
                       (state == WFD3));

  // ========================================
  // Fetch control and PMU
  // ========================================
  // Normal end of fill, or an error on a valid beat
  assign reissue = ((state == WFD1) && data_vld && !tsize) ||
                   ((state == WFD4) && data_vld) ||
                   (fill && trans_err);

  assign acc_err  = fill && trans_err;
  assign miss_pre = (state == WFD1) && beat;

endmodule

`default_nettype wire

/* hw/l1_refill_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module l1_refill_fsm (
  input  wire                          l1_refill_clk,
  input  wire                          cpurst_b,
  input  wire                          miss_req,
  input  wire                          inv_on,
  input  wire                          chgflw,
  input  wire                          grant,
  input  wire                          data_vld,
  input  wire                          trans_err,
  input  wire                          tsize,
  output logic                         start,
  output l1_refill_pkg::refill_state_t state,
  output logic                         ipb_req,
  output logic                         busy,
  output logic                         idle,
  output logic                         refill_on
);

  import l1_refill_pkg::*;

  refill_state_t next_state;
  logic          beat;

  // Any response consumes one beat
  assign beat  = data_vld || trans_err;
  // New miss only accepted from IDLE and with no invalidate running
  assign start = miss_req && !inv_on && (state == IDLE);

  // ========================================
  // State register
  // ========================================
  always_ff @(posedge l1_refill_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= IDLE;
    else
      state <= next_state;
  end

  // ========================================
  // Next state
  // ========================================
  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
        if (start)
          next_state = REQ;
      REQ:
        if (chgflw && !grant)
          next_state = IDLE;       // request dropped, bus ignores it
        else if (grant && chgflw)
          next_state = INV_WFD1;
        else if (grant)
          next_state = WFD1;
      WFD1:
        if (data_vld)
          next_state = tsize ? WFD2 : IDLE;
        else if (trans_err)
          next_state = tsize ? INV_WFD2 : IDLE;
        else if (chgflw)
          next_state = INV_WFD1;
      WFD2:
        if (data_vld)
          next_state = WFD3;
        else if (trans_err)
          next_state = INV_WFD3;
      WFD3:
        if (data_vld)
          next_state = WFD4;
        else if (trans_err)
          next_state = INV_WFD4;
      WFD4:
        if (beat)
          next_state = IDLE;
      // Discarded beats, just count them off
      INV_WFD1:
        if (beat)
          next_state = tsize ? INV_WFD2 : IDLE;
      INV_WFD2:
        if (beat)
          next_state = INV_WFD3;
      INV_WFD3:
        if (beat)
          next_state = INV_WFD4;
      INV_WFD4:
        if (beat)
          next_state = IDLE;
      default:
        next_state = IDLE;
    endcase
  end

  // ========================================
  // Status decodes
  // ========================================
  assign ipb_req   = (state == REQ);
  assign idle      = (state == IDLE);
  assign busy      = (state != IDLE);
  // Fetch stalls on PC while requesting or filling
  assign refill_on = (state == REQ) || state[st_fill_bit];

endmodule

`default_nettype wire

/* hw/l1_refill_pkg.sv */
`default_nettype none

package l1_refill_pkg;

  // ========================================
  // Widths
  // ========================================
  // Stored PCs are halfword aligned, bit 0 is implied
  localparam int pc_w     = 39;
  localparam int bus_pc_w = pc_w + 1;
  localparam int line_w   = 128;

  // Physical tag slice of the stored PC
  localparam int ptag_lsb = 11;
  localparam int ptag_w   = pc_w - ptag_lsb;

  typedef logic [pc_w-1:0]   pc_t;
  typedef logic [line_w-1:0] data_t;
  typedef logic [ptag_w-1:0] ptag_t;

  // ========================================
  // Refill FSM encoding
  // ========================================
  // Bit 2 marks a valid fill, bit 3 a discarded beat
  typedef enum logic [3:0] {
    IDLE     = 4'd0,
    REQ      = 4'd1,
    WFD1     = 4'd4,
    WFD2     = 4'd5,
    WFD3     = 4'd6,
    WFD4     = 4'd7,
    INV_WFD1 = 4'd8,
    INV_WFD2 = 4'd9,
    INV_WFD3 = 4'd10,
    INV_WFD4 = 4'd11
  } refill_state_t;

  localparam int st_fill_bit = 2;
  localparam int st_inv_bit  = 3;

endpackage

`default_nettype wire

/* hw/l1_refill_top.sv */
`timescale 1ns/10ps
`default_nettype none

module l1_refill_top (
  input  wire                                 l1_refill_clk,
  input  wire                                 cpurst_b,
  input  wire                                 miss_req,
  input  wire                                 inv_on,
  input  wire                                 miss_tsize,
  input  wire                                 miss_cacheable,
  input  wire                                 miss_bufferable,
  input  wire                                 miss_supv_mode,
  input  wire                                 miss_machine_mode,
  input  wire                                 miss_secure,
  input  l1_refill_pkg::pc_t                  miss_vpc,
  input  l1_refill_pkg::pc_t                  miss_ppc,
  input  wire                                 chgflw,
  input  wire                                 grant,
  input  wire                                 data_vld,
  input  wire                                 trans_err,
  input  l1_refill_pkg::data_t                rdata,
  output logic                                ipb_req,
  output logic [l1_refill_pkg::bus_pc_w-1:0]  ipb_vpc,
  output logic [l1_refill_pkg::bus_pc_w-1:0]  ipb_ppc,
  output logic                                ipb_tsize,
  output logic                                ipb_cacheable,
  output logic                                ipb_bufferable,
  output logic                                ipb_supv_mode,
  output logic                                ipb_machine_mode,
  output logic                                ipb_secure,
  output logic                                icache_wr,
  output logic                                icache_first,
  output logic                                icache_last,
  output l1_refill_pkg::pc_t                  icache_index,
  output l1_refill_pkg::ptag_t                icache_ptag,
  output l1_refill_pkg::data_t                icache_data,
  output logic                                reissue,
  output logic                                acc_err,
  output logic                                miss_pre,
  output logic                                busy,
  output logic                                idle,
  output logic                                refill_on
);

  import l1_refill_pkg::*;

  refill_state_t state;
  logic          start;
  logic          offset_inc;

  // ========================================
  // Control
  // ========================================
  l1_refill_fsm u_fsm (
    .l1_refill_clk (l1_refill_clk),
    .cpurst_b      (cpurst_b),
    .miss_req      (miss_req),
    .inv_on        (inv_on),
    .chgflw        (chgflw),
    .grant         (grant),
    .data_vld      (data_vld),
    .trans_err     (trans_err),
    .tsize         (ipb_tsize),
    .start         (start),
    .state         (state),
    .ipb_req       (ipb_req),
    .busy          (busy),
    .idle          (idle),
    .refill_on     (refill_on)
  );

  l1_refill_beat u_beat (
    .state        (state),
    .tsize        (ipb_tsize),
    .data_vld     (data_vld),
    .trans_err    (trans_err),
    .offset_inc   (offset_inc),
    .icache_wr    (icache_wr),
    .icache_first (icache_first),
    .icache_last  (icache_last),
    .reissue      (reissue),
    .acc_err      (acc_err),
    .miss_pre     (miss_pre)
  );

  // ========================================
  // Captured request fields
  // ========================================
  l1_refill_addr u_addr (
    .l1_refill_clk (l1_refill_clk),
    .cpurst_b      (cpurst_b),
    .start         (start),
    .offset_inc    (offset_inc),
    .miss_vpc      (miss_vpc),
    .miss_ppc      (miss_ppc),
    .icache_index  (icache_index),
    .icache_ptag   (icache_ptag),
    .ipb_vpc       (ipb_vpc),
    .ipb_ppc       (ipb_ppc)
  );

  l1_refill_attr u_attr (
    .l1_refill_clk     (l1_refill_clk),
    .cpurst_b          (cpurst_b),
    .start             (start),
    .miss_tsize        (miss_tsize),
    .miss_cacheable    (miss_cacheable),
    .miss_bufferable   (miss_bufferable),
    .miss_supv_mode    (miss_supv_mode),
    .miss_machine_mode (miss_machine_mode),
    .miss_secure       (miss_secure),
    .tsize             (ipb_tsize),
    .cacheable         (ipb_cacheable),
    .bufferable        (ipb_bufferable),
    .supv_mode         (ipb_supv_mode),
    .machine_mode      (ipb_machine_mode),
    .secure            (ipb_secure)
  );

  // ========================================
  // Data reorder
  // ========================================
  // Halfword order reversed, bytes inside a halfword kept
  for (genvar i = 0; i < line_w / 16; i++)
  begin : g_swap
    assign icache_data[16*i +: 16] = rdata[16*(line_w/16-1-i) +: 16];
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the refill controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module l1_refill_tb -f sources.f --Mdir obj_dir -o l1_refill_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/l1_refill_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST OK$" sim.log; then
  exit 0
fi
exit 1

/* sources.f */
hw/l1_refill_pkg.sv
hw/l1_refill_fsm.sv
hw/l1_refill_beat.sv
hw/l1_refill_addr.sv
hw/l1_refill_attr.sv
hw/l1_refill_top.sv
bench/l1_refill_props.sv
bench/l1_refill_tb.sv
